// File: verilog/mesh_pkg.sv
/*
 * Mesh package
 * Mesh size, tile coordinates, opcodes and the flit format shared by
 * the routers, the host tile and the memory tiles.
 */
package mesh_pkg;

  localparam int MeshDimX = 2;
  localparam int MeshDimY = 2;
  localparam int MemDepth = 16;
  localparam int HostX    = 0;
  localparam int HostY    = 0;

  typedef struct packed {
    logic x;
    logic y;
  } coord_t;

  typedef logic [$clog2(MemDepth)-1:0] addr_t;
  typedef logic [31:0]                 data_t;

  // Requests go host to memory, responses come back
  typedef enum logic [1:0] {
    OpRead     = 2'd0,
    OpWrite    = 2'd1,
    OpReadRsp  = 2'd2,
    OpWriteAck = 2'd3
  } opcode_e;

  typedef enum logic [2:0] {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Local = 3'd4
  } dir_e;

  typedef struct packed {
    logic    valid;
    opcode_e opcode;
    coord_t  dst;
    coord_t  src;
    addr_t   addr;
    data_t   data;
  } flit_t;

  typedef struct packed {
    opcode_e opcode;
    coord_t  dst;
    addr_t   addr;
    data_t   data;
  } host_req_t;

  typedef struct packed {
    opcode_e opcode;
    coord_t  src;
    data_t   data;
  } host_rsp_t;

  // Port on the neighbor that faces the given port
  function automatic dir_e opposite_dir(dir_e dir);
    case (dir)
      North:   return South;
      East:    return West;
      South:   return North;
      West:    return East;
      default: return Local;
    endcase
  endfunction

endpackage

// File: verilog/xy_router.sv
/*
 * XY router
 * Five-port mesh router with dimension-ordered routing. Every output
 * is registered, so a hop costs one cycle.
 */
module xy_router #(
  parameter int pos_x = 0,
  parameter int pos_y = 0
) (
  input  logic                                               clk_i,
  input  logic                                               arst_n_i,
  input  mesh_pkg::flit_t [mesh_pkg::Local:mesh_pkg::North] flit_i,
  output mesh_pkg::flit_t [mesh_pkg::Local:mesh_pkg::North] flit_o
);

  import mesh_pkg::*;

  flit_t [Local:North] flit_d;
  flit_t [Local:North] flit_q;

  // Resolve x first, then y
  function automatic dir_e route_dir(coord_t dst);
    if (int'(dst.x) > pos_x) begin
      return East;
    end
    if (int'(dst.x) < pos_x) begin
      return West;
    end
    if (int'(dst.y) > pos_y) begin
      return North;
    end
    if (int'(dst.y) < pos_y) begin
      return South;
    end
    return Local;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Output selection
  ////////////////////////////////////////////////////////////////////////////

  // Priority Local, North, East, South, West
  // Lower priority inputs are written first and get overwritten
  always_comb begin
    flit_d = '0;
    for (int i = int'(West); i >= int'(North); i--) begin
      if (flit_i[i].valid) begin
        flit_d[route_dir(flit_i[i].dst)] = flit_i[i];
      end
    end
    if (flit_i[Local].valid) begin
      flit_d[route_dir(flit_i[Local].dst)] = flit_i[Local];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      flit_q <= '0;
    end else begin
      flit_q <= flit_d;
    end
  end

  assign flit_o = flit_q;

endmodule

// File: verilog/mem_tile.sv
/*
 * Memory tile
 * Router plus a small scratchpad. Read and write packets arriving at
 * the local port are answered with a response to the sender.
 */
module mem_tile #(
  parameter int pos_x = 1,
  parameter int pos_y = 0
) (
  input  logic                                              clk_i,
  input  logic                                              arst_n_i,
  input  mesh_pkg::flit_t [mesh_pkg::West:mesh_pkg::North] flit_i,
  output mesh_pkg::flit_t [mesh_pkg::West:mesh_pkg::North] flit_o
);

  import mesh_pkg::*;

  flit_t [Local:North]  rtr_in;
  flit_t [Local:North]  rtr_out;
  flit_t                req;
  flit_t                rsp_d;
  flit_t                rsp_q;
  data_t [MemDepth-1:0] mem_q;

  // Response re-enters the mesh on the local port
  assign rtr_in = {rsp_q, flit_i};
  assign flit_o = rtr_out[West:North];
  assign req    = rtr_out[Local];

  xy_router #(
    .pos_x(pos_x),
    .pos_y(pos_y)
  ) xy_router_inst (
    .clk_i,
    .arst_n_i,
    .flit_i(rtr_in),
    .flit_o(rtr_out)
  );

  // Build the answer, read data unless it is a write
  always_comb begin
    rsp_d        = '0;
    rsp_d.dst    = req.src;
    rsp_d.src.x  = 1'(pos_x);
    rsp_d.src.y  = 1'(pos_y);
    rsp_d.addr   = req.addr;
    rsp_d.opcode = OpReadRsp;
    rsp_d.data   = mem_q[req.addr];
    if (req.opcode == OpWrite) begin
      rsp_d.opcode = OpWriteAck;
      rsp_d.data   = req.data;
    end
    rsp_d.valid = req.valid && (req.opcode inside {OpRead, OpWrite});
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mem_q <= '0;
      rsp_q <= '0;
    end else begin
      rsp_q <= rsp_d;
      if (req.valid && req.opcode == OpWrite) begin
        mem_q[req.addr] <= req.data;
      end
    end
  end

endmodule

// File: verilog/host_tile.sv
/*
 * Host tile
 * Router plus the command port. Turns one external command into a
 * packet, waits for its response and presents it at the outputs.
 */
module host_tile #(
  parameter int pos_x = 0,
  parameter int pos_y = 0
) (
  input  logic                                              clk_i,
  input  logic                                              arst_n_i,
  input  logic                                              req_valid_i,
  input  mesh_pkg::host_req_t                               req_i,
  output logic                                              busy_o,
  output logic                                              rsp_valid_o,
  output mesh_pkg::host_rsp_t                               rsp_o,
  input  mesh_pkg::flit_t [mesh_pkg::West:mesh_pkg::North] flit_i,
  output mesh_pkg::flit_t [mesh_pkg::West:mesh_pkg::North] flit_o
);

  import mesh_pkg::*;

  typedef enum logic {
    Idle,
    Wait
  } state_e;

  state_e              state_d;
  state_e              state_q;
  flit_t [Local:North] rtr_in;
  flit_t [Local:North] rtr_out;
  flit_t               inj_q;
  flit_t               loc;
  logic                to_self;
  logic                accept;
  logic                rsp_valid_q;
  host_rsp_t           rsp_q;

  assign rtr_in = {inj_q, flit_i};
  assign flit_o = rtr_out[West:North];
  assign loc    = rtr_out[Local];

  xy_router #(
    .pos_x(pos_x),
    .pos_y(pos_y)
  ) xy_router_inst (
    .clk_i,
    .arst_n_i,
    .flit_i(rtr_in),
    .flit_o(rtr_out)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Command acceptance, one transaction in flight
  ////////////////////////////////////////////////////////////////////////////

  assign to_self = (req_i.dst.x == 1'(pos_x)) && (req_i.dst.y == 1'(pos_y));
  assign accept  = req_valid_i && !busy_o && !to_self &&
                   (req_i.opcode inside {OpRead, OpWrite});

  // Stays busy through the response strobe
  assign busy_o = (state_q == Wait) || rsp_valid_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle:    if (accept) state_d = Wait;
      Wait:    if (loc.valid) state_d = Idle;
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= Idle;
      inj_q       <= '0;
      rsp_valid_q <= 1'b0;
      rsp_q       <= '0;
    end else begin
      state_q     <= state_d;
      inj_q.valid <= accept;
      if (accept) begin
        inj_q.opcode <= req_i.opcode;
        inj_q.dst    <= req_i.dst;
        inj_q.src.x  <= 1'(pos_x);
        inj_q.src.y  <= 1'(pos_y);
        inj_q.addr   <= req_i.addr;
        inj_q.data   <= req_i.data;
      end
      // Response capture
      rsp_valid_q <= loc.valid && (state_q == Wait);
      if (loc.valid) begin
        rsp_q.opcode <= loc.opcode;
        rsp_q.src    <= loc.src;
        rsp_q.data   <= loc.data;
      end
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

// File: verilog/mesh_top.sv
/*
 * Mesh top level
 * Places the host and memory tiles of the 2x2 mesh and connects every
 * router port to the facing port of its neighbor.
 */
module mesh_top (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                req_valid_i,
  input  mesh_pkg::host_req_t req_i,
  output logic                busy_o,
  output logic                rsp_valid_o,
  output mesh_pkg::host_rsp_t rsp_o
);

  import mesh_pkg::*;

  flit_t [MeshDimX-1:0][MeshDimY-1:0][West:North] flit_in;
  flit_t [MeshDimX-1:0][MeshDimY-1:0][West:North] flit_out;

  ////////////////////////////////////////////////////////////////////////////
  // Host tile
  ////////////////////////////////////////////////////////////////////////////

  host_tile #(
    .pos_x(HostX),
    .pos_y(HostY)
  ) host_tile_inst (
    .clk_i,
    .arst_n_i,
    .req_valid_i,
    .req_i,
    .busy_o,
    .rsp_valid_o,
    .rsp_o,
    .flit_i(flit_in[HostX][HostY]),
    .flit_o(flit_out[HostX][HostY])
  );

  ////////////////////////////////////////////////////////////////////////////
  // Memory tiles, every other position
  ////////////////////////////////////////////////////////////////////////////

  for (genvar x = 0; x < MeshDimX; x++) begin : gen_mem_x
    for (genvar y = 0; y < MeshDimY; y++) begin : gen_mem_y
      if (x != HostX || y != HostY) begin : gen_mem
        mem_tile #(
          .pos_x(x),
          .pos_y(y)
        ) mem_tile_inst (
          .clk_i,
          .arst_n_i,
          .flit_i(flit_in[x][y]),
          .flit_o(flit_out[x][y])
        );
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Neighbor links and edge tie-offs
  ////////////////////////////////////////////////////////////////////////////

  // North is +y, East is +x
  for (genvar x = 0; x < MeshDimX; x++) begin : gen_link_x
    for (genvar y = 0; y < MeshDimY; y++) begin : gen_link_y
      for (genvar d = int'(North); d <= int'(West); d++) begin : gen_dir
        if ((d == int'(North) && y == MeshDimY - 1) || (d == int'(South) && y == 0) ||
            (d == int'(East) && x == MeshDimX - 1) || (d == int'(West) && x == 0))
        begin : gen_tie_off
          assign flit_in[x][y][d] = '0;
        end else begin : gen_con
          assign flit_in[x][y][d] =
            flit_out[x + (d == int'(East)) - (d == int'(West))]
                    [y + (d == int'(North)) - (d == int'(South))]
                    [opposite_dir(dir_e'(d))];
        end
      end
    end
  end

endmodule

// File: verification/mesh_tb.sv
/*
 * Mesh testbench
 * Sends read and write commands to the memory tiles of the 2x2 mesh and
 * checks every response against a reference model of the scratchpads.
 */
module mesh_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import mesh_pkg::*;

  localparam int Seed        = 25593;
  localparam int DriveDelay  = 5;
  localparam int RspTimeout  = 12;
  localparam int NumRandom   = 6;
  localparam int NumRequests = 3 + 3 + 6 + 2 * NumRandom + 3 + 1;
  localparam int CycleLimit  = 40 * NumRequests + 100;

  logic      clk;
  logic      arst_n;
  logic      req_valid;
  host_req_t req;
  logic      busy;
  logic      rsp_valid;
  host_rsp_t rsp;

  int        errors;
  int        cycles;
  data_t     model [MeshDimX][MeshDimY][MemDepth];

  mesh_top mesh_top_inst (
    .clk_i      (clk),
    .arst_n_i   (arst_n),
    .req_valid_i(req_valid),
    .req_i      (req),
    .busy_o     (busy),
    .rsp_valid_o(rsp_valid),
    .rsp_o      (rsp)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CycleLimit) begin
      $display("Timeout after %0d cycles, the run did not complete", cycles);
      $display("Errors: %0d", errors);
      $display("Finished with errors");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Protocol checks
  ////////////////////////////////////////////////////////////////////////////

  // Response is a one-cycle strobe
  assert property (@(posedge clk) disable iff (!arst_n) rsp_valid |=> !rsp_valid)
    else begin
      errors++;
      $display("Mismatch at %0t: rsp_valid_o got 1 expected 0", $time);
    end

  assert property (@(posedge clk) disable iff (!arst_n) rsp_valid |-> busy)
    else begin
      errors++;
      $display("Mismatch at %0t: busy_o got 0 expected 1", $time);
    end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Index 0..2 maps to (1,0), (0,1), (1,1)
  function automatic coord_t tile_of(int idx);
    coord_t c;
    int     n;
    n   = idx + 1;
    c.x = n[0];
    c.y = n[1];
    return c;
  endfunction

  task automatic send_request(input opcode_e op, input coord_t dst, input addr_t addr,
                              input data_t data);
    @(posedge clk);
    #DriveDelay;
    req_valid   = 1'b1;
    req.opcode  = op;
    req.dst     = dst;
    req.addr    = addr;
    req.data    = data;
    @(posedge clk);
    #DriveDelay;
    req_valid = 1'b0;
  endtask

  task automatic wait_response(output logic got, output host_rsp_t r);
    got = 1'b0;
    r   = '0;
    for (int i = 0; i < RspTimeout && !got; i++) begin
      @(negedge clk);
      if (rsp_valid) begin
        got = 1'b1;
        r   = rsp;
      end
    end
  endtask

  task automatic check_response(input host_rsp_t r, input opcode_e exp_op,
                                input coord_t exp_src, input data_t exp_data);
    assert (r.opcode == exp_op) else begin
      errors++;
      $display("Mismatch at %0t: rsp_o.opcode got %0d expected %0d", $time, r.opcode, exp_op);
    end
    assert (r.src == exp_src) else begin
      errors++;
      $display("Mismatch at %0t: rsp_o.src got %b expected %b", $time, r.src, exp_src);
    end
    assert (r.data == exp_data) else begin
      errors++;
      $display("Mismatch at %0t: rsp_o.data got %h expected %h", $time, r.data, exp_data);
    end
  endtask

  // One full transaction, expected values from the model
  task automatic transact(input opcode_e op, input coord_t dst, input addr_t addr,
                          input data_t data);
    host_rsp_t r;
    logic      got;
    opcode_e   exp_op;
    data_t     exp_data;
    exp_op   = (op == OpWrite) ? OpWriteAck : OpReadRsp;
    exp_data = (op == OpWrite) ? data : model[dst.x][dst.y][addr];
    if (op == OpWrite) begin
      model[dst.x][dst.y][addr] = data;
    end
    send_request(op, dst, addr, data);
    wait_response(got, r);
    if (!got) begin
      errors++;
      $display("Response missing at %0t for request to tile (%0d,%0d)", $time, dst.x, dst.y);
    end else begin
      check_response(r, exp_op, dst, exp_data);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    host_rsp_t r;
    logic      got;
    addr_t     a;
    data_t     d;
    coord_t    host_pos;
    addr_t     rnd_addr [NumRandom];
    int        rnd_tile [NumRandom];

    clk       = 1'b0;
    arst_n    = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    errors    = 0;
    cycles    = 0;
    void'($urandom(Seed));
    host_pos.x = 1'(HostX);
    host_pos.y = 1'(HostY);
    for (int x = 0; x < MeshDimX; x++) begin
      for (int y = 0; y < MeshDimY; y++) begin
        for (int i = 0; i < MemDepth; i++) begin
          model[x][y][i] = '0;
        end
      end
    end

    repeat (2) @(posedge clk);
    #DriveDelay;
    arst_n = 1'b1;

    // Idle after reset, scratchpads read zero
    @(negedge clk);
    assert (!busy && !rsp_valid) else begin
      errors++;
      $display("Mismatch at %0t: busy_o/rsp_valid_o got %b%b expected 00", $time, busy,
               rsp_valid);
    end
    for (int t = 0; t < 3; t++) begin
      transact(OpRead, tile_of(t), addr_t'($urandom % MemDepth), '0);
    end

    for (int t = 0; t < 3; t++) begin
      transact(OpWrite, tile_of(t), addr_t'($urandom % MemDepth), $urandom);
    end

    // Same address on every tile
    a = addr_t'($urandom % MemDepth);
    d = $urandom;
    for (int t = 0; t < 3; t++) begin
      transact(OpWrite, tile_of(t), a, d + data_t'(t));
    end
    for (int t = 0; t < 3; t++) begin
      transact(OpRead, tile_of(t), a, '0);
    end

    for (int i = 0; i < NumRandom; i++) begin
      rnd_addr[i] = addr_t'($urandom % MemDepth);
      rnd_tile[i] = int'($urandom % 3);
      transact(OpWrite, tile_of(rnd_tile[i]), rnd_addr[i], $urandom);
    end
    for (int i = 0; i < NumRandom; i++) begin
      transact(OpRead, tile_of(rnd_tile[i]), rnd_addr[i], '0);
    end

    // Second command while busy is dropped
    a = addr_t'($urandom % MemDepth);
    d = $urandom;
    send_request(OpWrite, tile_of(2), a, d);
    model[1][1][a] = d;
    @(negedge clk);
    assert (busy) else begin
      errors++;
      $display("Mismatch at %0t: busy_o got 0 expected 1", $time);
    end
    send_request(OpWrite, tile_of(0), a, ~d);
    wait_response(got, r);
    if (!got) begin
      errors++;
      $display("Response missing at %0t for the accepted write", $time);
    end else begin
      check_response(r, OpWriteAck, tile_of(2), d);
    end
    @(negedge clk);
    assert (!busy) else begin
      errors++;
      $display("Mismatch at %0t: busy_o got 1 expected 0", $time);
    end
    wait_response(got, r);
    if (got) begin
      errors++;
      $display("Unexpected response at %0t to a request issued while busy", $time);
    end
    transact(OpRead, tile_of(0), a, '0);

    // Request to the host itself
    send_request(OpRead, host_pos, '0, '0);
    @(negedge clk);
    assert (!busy) else begin
      errors++;
      $display("Mismatch at %0t: busy_o got 1 expected 0", $time);
    end
    wait_response(got, r);
    if (got) begin
      errors++;
      $display("Unexpected response at %0t to a request addressed to the host", $time);
    end

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: compile.f
verilog/mesh_pkg.sv
verilog/xy_router.sv
verilog/mem_tile.sv
verilog/host_tile.sv
verilog/mesh_top.sv
verification/mesh_tb.sv

// File: Bender.yml
package:
  name: mesh_noc

sources:
  - verilog/mesh_pkg.sv
  - verilog/xy_router.sv
  - verilog/mem_tile.sv
  - verilog/host_tile.sv
  - verilog/mesh_top.sv
  - target: test
    files:
      - verification/mesh_tb.sv
